/* logic/fetch_pkg.sv */
package fetch_pkg;

	// ******************************
	// widths
	// ******************************

	// pc and memory beat width
	localparam int XLEN = 64;
	// one instruction is half a beat
	localparam int INST_W = 32;
	// read response code width
	localparam int RESP_W = 2;

	// first fetch address out of reset
	localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

	// ******************************
	// queue and timer sizing
	// ******************************

	localparam int QUEUE_DEPTH = 2;
	// pointer and occupancy widths for the instruction queue
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

	// wait cycles without rvalid before fetch gives up
	localparam int TIMEOUT_CYCLES = 16;
	localparam int TIMER_W = 5;

	// fetch controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT,
		ST_DROP,
		ST_HALT
	} fetch_state_e;

	// reported reason for a halted fetch
	typedef enum logic [1:0] {
		FAULT_NONE,
		FAULT_BUS,
		FAULT_TIMEOUT
	} fault_cause_e;

endpackage

/* logic/inst_push_if.sv */
interface inst_push_if;

	// pc/instruction pair offered to the queue
	logic push_valid;
	logic [fetch_pkg::XLEN-1:0] push_pc;
	logic [fetch_pkg::INST_W-1:0] push_inst;
	// queue has a free entry
	logic push_ready;
	// redirect, empties the queue
	logic flush;

	// producer side, the fetch controller
	modport ctrl (
		output push_valid,
		output push_pc,
		output push_inst,
		output flush,
		input  push_ready
	);

	// consumer side, the instruction queue
	modport queue (
		input  push_valid,
		input  push_pc,
		input  push_inst,
		input  flush,
		output push_ready
	);

endinterface

/* logic/pc_gen.sv */
module pc_gen (
	input  logic clk,
	input  logic arst_n,
	// step to the next sequential instruction
	input  logic advance,
	// redirect from the back end
	input  logic pc_update,
	input  logic [fetch_pkg::XLEN-1:0] dnpc,
	output logic [fetch_pkg::XLEN-1:0] pc
);

	logic [fetch_pkg::XLEN-1:0] pc_next;

	// redirect wins over a sequential step
	always_comb begin
		pc_next = pc;
		if (pc_update) begin
			pc_next = dnpc;
		end else if (advance) begin
			// fixed 4 byte instructions, no compressed
			pc_next = pc + fetch_pkg::XLEN'(4);
		end
	end

	// fetch pc register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= fetch_pkg::RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

/* logic/resp_timer.sv */
module resp_timer (
	input  logic clk,
	input  logic arst_n,
	// a response is owed and rvalid is still low
	input  logic waiting,
	output logic timeout
);

	logic [fetch_pkg::TIMER_W-1:0] count;

	// limit reached, held until waiting drops
	assign timeout = (count == fetch_pkg::TIMER_W'(fetch_pkg::TIMEOUT_CYCLES));

	// clears on any non waiting cycle
	// saturates at the limit
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (!waiting) begin
			count <= '0;
		end else if (!timeout) begin
			count <= count + 1'b1;
		end
	end

endmodule

/* logic/fetch_ctrl.sv */
module fetch_ctrl (
	input  logic clk,
	input  logic arst_n,
	// current fetch pc from pc_gen
	input  logic [fetch_pkg::XLEN-1:0] pc,
	input  logic pc_update,
	// read address channel
	output logic arvalid,
	output logic [fetch_pkg::XLEN-1:0] araddr,
	input  logic arready,
	// read data channel
	input  logic rvalid,
	input  logic [fetch_pkg::XLEN-1:0] rdata,
	input  logic [fetch_pkg::RESP_W-1:0] rresp,
	output logic rready,
	// response timer
	input  logic timeout,
	output logic waiting,
	// pc step request
	output logic advance,
	inst_push_if.ctrl push,
	// fault report
	output logic fault,
	output fetch_pkg::fault_cause_e fault_cause,
	output logic [fetch_pkg::XLEN-1:0] fault_pc
);

	fetch_pkg::fetch_state_e state_q;
	fetch_pkg::fetch_state_e state_d;
	logic r_hs;
	logic resp_ok;

	// ******************************
	// handshakes
	// ******************************

	assign r_hs    = rvalid && rready;
	assign resp_ok = (rresp == '0);

	// one request at a time, beat aligned
	assign arvalid = (state_q == fetch_pkg::ST_REQ);
	assign araddr  = {pc[fetch_pkg::XLEN-1:3], 3'b000};

	// take data only when the queue can hold it
	// drop state sinks whatever comes back
	always_comb begin
		case (state_q)
			fetch_pkg::ST_WAIT: rready = push.push_ready;
			fetch_pkg::ST_DROP: rready = 1'b1;
			default:            rready = 1'b0;
		endcase
	end

	// timer runs while a response is owed but not shown
	assign waiting = ((state_q == fetch_pkg::ST_WAIT) || (state_q == fetch_pkg::ST_DROP))
		&& !rvalid;

	// push good data unless a redirect makes it stale
	assign push.push_valid = (state_q == fetch_pkg::ST_WAIT) && rvalid && resp_ok
		&& !pc_update;
	assign push.push_pc    = pc;
	// pc bit 2 picks the upper half of the beat
	assign push.push_inst  = pc[2] ? rdata[fetch_pkg::XLEN-1:fetch_pkg::INST_W]
		: rdata[fetch_pkg::INST_W-1:0];
	assign push.flush      = pc_update;

	assign advance = push.push_valid && push.push_ready;

	// ******************************
	// state machine
	// ******************************

	always_comb begin
		state_d = state_q;
		case (state_q)
			fetch_pkg::ST_IDLE: begin
				state_d = fetch_pkg::ST_REQ;
			end
			fetch_pkg::ST_REQ: begin
				// address taken together with a redirect, so its data is stale
				if (arvalid && arready) begin
					state_d = pc_update ? fetch_pkg::ST_DROP : fetch_pkg::ST_WAIT;
				end
			end
			fetch_pkg::ST_WAIT: begin
				if (pc_update) begin
					state_d = r_hs ? fetch_pkg::ST_REQ : fetch_pkg::ST_DROP;
				end else if (r_hs) begin
					state_d = resp_ok ? fetch_pkg::ST_REQ : fetch_pkg::ST_HALT;
				end else if (timeout) begin
					state_d = fetch_pkg::ST_HALT;
				end
			end
			fetch_pkg::ST_DROP: begin
				// give up on a response that never shows
				if (r_hs || timeout) begin
					state_d = fetch_pkg::ST_REQ;
				end
			end
			fetch_pkg::ST_HALT: begin
				// a timed out response may still be in flight
				if (pc_update) begin
					state_d = (fault_cause == fetch_pkg::FAULT_TIMEOUT) ?
						fetch_pkg::ST_DROP : fetch_pkg::ST_REQ;
				end
			end
			default: begin
				state_d = fetch_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= fetch_pkg::ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// ******************************
	// fault report
	// ******************************

	// set on entry to halt, cleared by redirect
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fault       <= 1'b0;
			fault_cause <= fetch_pkg::FAULT_NONE;
			fault_pc    <= '0;
		end else if (pc_update) begin
			fault       <= 1'b0;
			fault_cause <= fetch_pkg::FAULT_NONE;
		end else if ((state_q == fetch_pkg::ST_WAIT) && r_hs && !resp_ok) begin
			fault       <= 1'b1;
			fault_cause <= fetch_pkg::FAULT_BUS;
			fault_pc    <= pc;
		end else if ((state_q == fetch_pkg::ST_WAIT) && !r_hs && timeout) begin
			fault       <= 1'b1;
			fault_cause <= fetch_pkg::FAULT_TIMEOUT;
			fault_pc    <= pc;
		end
	end

endmodule

/* logic/inst_queue.sv */
module inst_queue (
	input  logic clk,
	input  logic arst_n,
	inst_push_if.queue push,
	// downstream stage
	output logic inst_valid,
	output logic [fetch_pkg::XLEN-1:0] inst_pc,
	output logic [fetch_pkg::INST_W-1:0] inst,
	input  logic inst_ready
);

	logic [fetch_pkg::XLEN-1:0] pc_mem [fetch_pkg::QUEUE_DEPTH];
	logic [fetch_pkg::INST_W-1:0] inst_mem [fetch_pkg::QUEUE_DEPTH];
	logic [fetch_pkg::QPTR_W-1:0] wr_ptr;
	logic [fetch_pkg::QPTR_W-1:0] rd_ptr;
	logic [fetch_pkg::QCNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	// pointer step with wrap at the last entry
	function automatic logic [fetch_pkg::QPTR_W-1:0] ptr_next(
		input logic [fetch_pkg::QPTR_W-1:0] p
	);
		return (p == fetch_pkg::QPTR_W'(fetch_pkg::QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign push.push_ready = (count != fetch_pkg::QCNT_W'(fetch_pkg::QUEUE_DEPTH));
	assign inst_valid      = (count != '0);
	assign inst_pc         = pc_mem[rd_ptr];
	assign inst            = inst_mem[rd_ptr];

	// flush beats both sides
	assign do_push = push.push_valid && push.push_ready && !push.flush;
	assign do_pop  = inst_valid && inst_ready && !push.flush;

	// ******************************
	// pointers and count
	// ******************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (push.flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			// simultaneous push and pop leave the count alone
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// entry storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			pc_mem[wr_ptr]   <= push.push_pc;
			inst_mem[wr_ptr] <= push.push_inst;
		end
	end

endmodule

/* logic/fetch_top.sv */
module fetch_top (
	input  logic clk,
	input  logic arst_n,
	// read address channel
	output logic arvalid,
	output logic [fetch_pkg::XLEN-1:0] araddr,
	input  logic arready,
	// read data channel
	input  logic rvalid,
	input  logic [fetch_pkg::XLEN-1:0] rdata,
	input  logic [fetch_pkg::RESP_W-1:0] rresp,
	output logic rready,
	// redirect
	input  logic pc_update,
	input  logic [fetch_pkg::XLEN-1:0] dnpc,
	// instruction output
	output logic inst_valid,
	output logic [fetch_pkg::XLEN-1:0] inst_pc,
	output logic [fetch_pkg::INST_W-1:0] inst,
	input  logic inst_ready,
	// fault report
	output logic fault,
	output fetch_pkg::fault_cause_e fault_cause,
	output logic [fetch_pkg::XLEN-1:0] fault_pc
);

	logic [fetch_pkg::XLEN-1:0] pc;
	logic advance;
	logic waiting;
	logic timeout;

	// controller to queue
	inst_push_if push_bus ();

	// ******************************
	// datapath and control
	// ******************************

	pc_gen u_pc_gen (
		.clk       (clk),
		.arst_n    (arst_n),
		.advance   (advance),
		.pc_update (pc_update),
		.dnpc      (dnpc),
		.pc        (pc)
	);

	resp_timer u_resp_timer (
		.clk     (clk),
		.arst_n  (arst_n),
		.waiting (waiting),
		.timeout (timeout)
	);

	fetch_ctrl u_fetch_ctrl (
		.clk         (clk),
		.arst_n      (arst_n),
		.pc          (pc),
		.pc_update   (pc_update),
		.arvalid     (arvalid),
		.araddr      (araddr),
		.arready     (arready),
		.rvalid      (rvalid),
		.rdata       (rdata),
		.rresp       (rresp),
		.rready      (rready),
		.timeout     (timeout),
		.waiting     (waiting),
		.advance     (advance),
		.push        (push_bus.ctrl),
		.fault       (fault),
		.fault_cause (fault_cause),
		.fault_pc    (fault_pc)
	);

	// output buffer toward decode
	inst_queue u_inst_queue (
		.clk        (clk),
		.arst_n     (arst_n),
		.push       (push_bus.queue),
		.inst_valid (inst_valid),
		.inst_pc    (inst_pc),
		.inst       (inst),
		.inst_ready (inst_ready)
	);

endmodule

/* test/fetch_checker.sv */
module fetch_checker #(
	parameter logic [31:0] DATA_XOR = 32'h0
) (
	input  logic clk,
	input  logic arst_n,
	input  logic arvalid,
	input  logic [fetch_pkg::XLEN-1:0] araddr,
	input  logic pc_update,
	input  logic [fetch_pkg::XLEN-1:0] dnpc,
	input  logic inst_valid,
	input  logic [fetch_pkg::XLEN-1:0] inst_pc,
	input  logic [fetch_pkg::INST_W-1:0] inst,
	input  logic inst_ready,
	input  logic fault,
	input  fetch_pkg::fault_cause_e fault_cause,
	input  logic [fetch_pkg::XLEN-1:0] fault_pc,
	// test bookkeeping from the stimulus side
	input  int test_id,
	input  logic test_start,
	input  logic test_end,
	input  fetch_pkg::fault_cause_e exp_cause,
	input  logic [fetch_pkg::XLEN-1:0] exp_fault_pc,
	output int accepted,
	output logic fault_seen,
	output int errors,
	output int tests_failed
);

	// fixed first fetch address of the core
	localparam logic [fetch_pkg::XLEN-1:0] BOOT_PC = 64'h0000_0000_8000_0000;

	logic [fetch_pkg::XLEN-1:0] exp_pc;
	logic [fetch_pkg::XLEN-1:0] hold_pc;
	logic [fetch_pkg::INST_W-1:0] hold_inst;
	int acc_cnt;
	int test_errs;
	logic seen;
	logic fault_q;
	logic first_req;
	logic hold_q;
	logic clear_due;

	task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
		$display("FAILED %s expected 0x%h actual 0x%h in test %0d", name, exp, act, test_id);
		test_errs++;
		errors++;
	endtask

	task automatic other_error(input string msg);
		$display("error in test %0d: %s", test_id, msg);
		test_errs++;
		errors++;
	endtask

	// all inputs sampled at the edge, before the DUT flops move
	always @(posedge clk) begin
		if (!arst_n) begin
			exp_pc = BOOT_PC;
			acc_cnt = 0;
			test_errs = 0;
			errors = 0;
			tests_failed = 0;
			seen = 1'b0;
			fault_q = 1'b0;
			first_req = 1'b1;
			hold_q = 1'b0;
			clear_due = 1'b0;
		end else begin
			if (test_start) begin
				acc_cnt = 0;
				test_errs = 0;
				seen = 1'b0;
			end
			// first request out of reset
			if (first_req && arvalid) begin
				if (araddr !== BOOT_PC) begin
					value_error("araddr", BOOT_PC, araddr);
				end
				first_req = 1'b0;
			end
			if (hold_q && (!inst_valid || inst_pc !== hold_pc || inst !== hold_inst)) begin
				other_error("instruction output changed while waiting for inst_ready");
			end
			// a pop in a redirect cycle is flushed, not delivered
			if (inst_valid && inst_ready && !pc_update) begin
				if (inst_pc !== exp_pc) begin
					value_error("inst_pc", exp_pc, inst_pc);
				end
				if (inst !== (inst_pc[31:0] ^ DATA_XOR)) begin
					value_error("inst", 64'(inst_pc[31:0] ^ DATA_XOR), 64'(inst));
				end
				if (exp_cause != fetch_pkg::FAULT_NONE && inst_pc == exp_fault_pc) begin
					other_error("the faulting pc was delivered as an instruction");
				end
				// next expected pc follows the one just delivered
				exp_pc = inst_pc + 64'd4;
				acc_cnt++;
			end
			hold_q = inst_valid && !inst_ready && !pc_update;
			hold_pc = inst_pc;
			hold_inst = inst;
			if (pc_update) begin
				exp_pc = dnpc;
			end
			// fault register clears on the redirect edge
			if (clear_due && fault) begin
				other_error("fault still set after a redirect");
			end
			clear_due = pc_update;
			if (fault && !fault_q) begin
				if (exp_cause == fetch_pkg::FAULT_NONE) begin
					other_error("fault raised where none was expected");
				end else begin
					if (fault_cause !== exp_cause) begin
						value_error("fault_cause", 64'(exp_cause), 64'(fault_cause));
					end
					if (fault_pc !== exp_fault_pc) begin
						value_error("fault_pc", exp_fault_pc, fault_pc);
					end
				end
				seen = 1'b1;
			end
			fault_q = fault;
			if (test_end) begin
				if (exp_cause != fetch_pkg::FAULT_NONE && !seen) begin
					other_error("no fault was reported");
				end
				if (test_errs == 0) begin
					$display("test %0d passed, %0d instructions", test_id, acc_cnt);
				end else begin
					$display("test %0d failed with %0d errors", test_id, test_errs);
					tests_failed++;
				end
			end
		end
		// stimulus side polls these, so they move after the edge
		accepted <= acc_cnt;
		fault_seen <= seen;
	end

endmodule

/* test/fetch_tb.sv */
module fetch_tb;

	localparam int FIELDS = 9;
	localparam int MAX_RECS = 16;
	// every word at byte address a holds a[31:0] xor this
	localparam logic [31:0] DATA_XOR = 32'h1357_9bdf;
	// cycles allowed for an owed fault after the last good instruction
	localparam int FAULT_WAIT = 4 * fetch_pkg::TIMEOUT_CYCLES;

	logic clk;
	logic arst_n;
	logic arvalid;
	logic [fetch_pkg::XLEN-1:0] araddr;
	logic arready;
	logic rvalid;
	logic [fetch_pkg::XLEN-1:0] rdata;
	logic [fetch_pkg::RESP_W-1:0] rresp;
	logic rready;
	logic pc_update;
	logic [fetch_pkg::XLEN-1:0] dnpc;
	logic inst_valid;
	logic [fetch_pkg::XLEN-1:0] inst_pc;
	logic [fetch_pkg::INST_W-1:0] inst;
	logic inst_ready;
	logic fault;
	fetch_pkg::fault_cause_e fault_cause;
	logic [fetch_pkg::XLEN-1:0] fault_pc;

	logic [63:0] stim [FIELDS*MAX_RECS];
	int n_recs;
	longint unsigned wd_limit;
	int unsigned rng_init;
	// memory model setup for the running record
	logic [31:0] max_lat;
	logic [31:0] stall_pct;
	logic [1:0] mode;
	logic [63:0] bad_addr;
	// checker side
	int test_id;
	logic test_start;
	logic test_end;
	fetch_pkg::fault_cause_e exp_cause;
	logic [63:0] exp_fault_pc;
	int accepted;
	logic fault_seen;
	int errors;
	int tests_failed;

	fetch_top u_dut (.*);

	fetch_checker #(.DATA_XOR(DATA_XOR)) u_checker (.*);

	function automatic logic [31:0] mem_word(input logic [63:0] a);
		return a[31:0] ^ DATA_XOR;
	endfunction

	function automatic fetch_pkg::fault_cause_e cause_for_mode(input logic [1:0] m);
		case (m)
			2'd1:    return fetch_pkg::FAULT_BUS;
			2'd2:    return fetch_pkg::FAULT_TIMEOUT;
			default: return fetch_pkg::FAULT_NONE;
		endcase
	endfunction

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ******************************
	// memory and downstream models
	// ******************************

	// one beat per request after a random delay
	initial begin : memory_model
		logic [63:0] req_addr;
		int unsigned delay;
		forever begin
			@(posedge clk);
			if (arvalid && arready) begin
				req_addr = araddr;
				arready <= 1'b0;
				delay = $urandom_range(max_lat, 0);
				repeat (delay) @(posedge clk);
				// silent address never answers
				if (!(mode == 2'd2 && req_addr == bad_addr)) begin
					rvalid <= 1'b1;
					rdata <= {mem_word(req_addr + 64'd4), mem_word(req_addr)};
					rresp <= (mode == 2'd1 && req_addr == bad_addr) ? 2'b01 : 2'b00;
					@(posedge clk);
					while (!rready) @(posedge clk);
					rvalid <= 1'b0;
				end
			end else begin
				arready <= ($urandom_range(3, 0) != 0);
			end
		end
	end

	initial begin : ready_driver
		forever begin
			@(posedge clk);
			inst_ready <= ($urandom_range(99, 0) >= stall_pct);
		end
	end

	// ******************************
	// test sequence
	// ******************************

	task automatic redirect(input logic [63:0] target);
		pc_update <= 1'b1;
		dnpc <= target;
		@(posedge clk);
		pc_update <= 1'b0;
		test_start <= 1'b0;
	endtask

	task automatic run_test(input int idx);
		int base;
		int count;
		int redir_pos;
		logic [1:0] rec_mode;
		base = idx * FIELDS;
		count = int'(stim[base + 2]);
		redir_pos = int'(stim[base + 5]);
		rec_mode = stim[base + 7][1:0];
		@(posedge clk);
		max_lat <= stim[base + 3][31:0];
		stall_pct <= stim[base + 4][31:0];
		mode <= rec_mode;
		bad_addr <= stim[base + 8];
		test_id <= int'(stim[base]);
		exp_cause <= cause_for_mode(rec_mode);
		exp_fault_pc <= stim[base + 8];
		test_start <= 1'b1;
		// record 0 runs from the reset pc
		if (idx != 0) begin
			redirect(stim[base + 1]);
		end else begin
			@(posedge clk);
			test_start <= 1'b0;
		end
		@(posedge clk);
		if (redir_pos != 0) begin
			while (accepted < redir_pos) @(posedge clk);
			redirect(stim[base + 6]);
		end
		while (accepted < count) @(posedge clk);
		// the fault follows the last good instruction within a few timer periods
		if (rec_mode != 2'd0) begin
			for (int c = 0; c < FAULT_WAIT && !fault_seen; c++) begin
				@(posedge clk);
			end
		end
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
	endtask

	initial begin : main
		arst_n = 1'b0;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rresp = '0;
		pc_update = 1'b0;
		dnpc = '0;
		inst_ready = 1'b0;
		max_lat = '0;
		stall_pct = '0;
		mode = 2'd0;
		bad_addr = '0;
		test_id = 0;
		test_start = 1'b0;
		test_end = 1'b0;
		exp_cause = fetch_pkg::FAULT_NONE;
		exp_fault_pc = '0;
		wd_limit = 0;
		rng_init = $urandom(32'hdd24_9149);
		$readmemh("test/fetch_stimulus.txt", stim);
		n_recs = 0;
		while (n_recs < MAX_RECS && !$isunknown(stim[n_recs * FIELDS])) begin
			n_recs++;
		end
		// budget of about four times a plain run per record
		for (int i = 0; i < n_recs; i++) begin
			wd_limit += stim[i * FIELDS + 2] * (stim[i * FIELDS + 3] + 4) * 8 * 4;
		end
		wd_limit += 2000 * n_recs + 1;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		for (int i = 0; i < n_recs; i++) begin
			run_test(i);
		end
		repeat (4) @(posedge clk);
		$display("tests run %0d, failed %0d, errors %0d", n_recs, tests_failed, errors);
		if (n_recs > 0 && errors == 0 && tests_failed == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		wait (wd_limit != 0);
		#(wd_limit);
		$display("watchdog: tests did not complete within %0d time units", wd_limit);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* list.f */
logic/fetch_pkg.sv
logic/inst_push_if.sv
logic/pc_gen.sv
logic/resp_timer.sv
logic/fetch_ctrl.sv
logic/inst_queue.sv
logic/fetch_top.sv
test/fetch_checker.sv
test/fetch_tb.sv

/* test/fetch_stimulus.txt */
// id start_pc count max_latency stall_pct redirect_after redirect_target mode fault_addr
// all fields hex; mode 0 plain, 1 bus error at fault_addr, 2 no response at fault_addr
0 80000000 8 0 0 0 0 0 0
1 80001000 18 3 0 0 0 0 0
2 80002004 1e 6 28 0 0 0 0
3 80003000 14 1 4b 0 0 0 0
4 80004000 14 5 14 6 80008010 0 0
5 80005008 10 0 1e 3 8000900c 0 0
6 80006000 4 2 19 0 0 1 80006010
7 80007004 5 3 0 0 0 2 80007018
8 80000100 c 4 a 0 0 0 0
9 8000a000 0 2 0 0 0 1 8000a000
a 8000b00c 10 7 32 8 8000c004 0 0
